// File: verilog/isa_pkg.sv
/*
 * isa_pkg: instruction word layouts and opcode / function codes of the
 * Alpha-style integer subset handled by the execute slice
 */
`default_nettype none

package isa_pkg;

	// one instruction word, seen as operate or memory/branch format
	// in operate register form rb sits in lit[7:3], the same bits as mem_fmt.rb
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] ra;
			logic [7:0] lit;      // zero-extended literal when lit_flag set
			logic       lit_flag;
			logic [6:0] func;
			logic [4:0] rc;       // destination
		} op_fmt;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  ra;
			logic [4:0]  rb;
			logic [15:0] disp;    // signed byte displacement
		} mem_fmt;
		logic [31:0] bits;        // raw word, branch disp in [20:0], cond in [28:26]
	} inst_t;

	//////////////////////////////
	// opcodes
	localparam logic [5:0] OP_LDA  = 6'h08;
	localparam logic [5:0] OP_INTA = 6'h10; // add, sub, compares
	localparam logic [5:0] OP_INTL = 6'h11; // logicals
	localparam logic [5:0] OP_INTS = 6'h12; // shifts
	localparam logic [5:0] OP_INTM = 6'h13; // multiply
	localparam logic [5:0] OP_BR   = 6'h30;
	localparam logic [5:0] OP_BLBC = 6'h38;
	localparam logic [5:0] OP_BEQ  = 6'h39;
	localparam logic [5:0] OP_BLT  = 6'h3a;
	localparam logic [5:0] OP_BLE  = 6'h3b;
	localparam logic [5:0] OP_BLBS = 6'h3c;
	localparam logic [5:0] OP_BNE  = 6'h3d;
	localparam logic [5:0] OP_BGE  = 6'h3e;
	localparam logic [5:0] OP_BGT  = 6'h3f;

	//////////////////////////////
	// operate function codes, only unique within their group
	localparam logic [6:0] FN_ADDQ   = 7'h20;
	localparam logic [6:0] FN_SUBQ   = 7'h29;
	localparam logic [6:0] FN_CMPULT = 7'h1d;
	localparam logic [6:0] FN_CMPEQ  = 7'h2d;
	localparam logic [6:0] FN_CMPULE = 7'h3d;
	localparam logic [6:0] FN_CMPLT  = 7'h4d;
	localparam logic [6:0] FN_CMPLE  = 7'h6d;
	localparam logic [6:0] FN_AND    = 7'h00;
	localparam logic [6:0] FN_BIC    = 7'h08;
	localparam logic [6:0] FN_BIS    = 7'h20;
	localparam logic [6:0] FN_ORNOT  = 7'h28;
	localparam logic [6:0] FN_XOR    = 7'h40;
	localparam logic [6:0] FN_EQV    = 7'h48;
	localparam logic [6:0] FN_SRL    = 7'h34;
	localparam logic [6:0] FN_SLL    = 7'h39;
	localparam logic [6:0] FN_SRA    = 7'h3c;
	localparam logic [6:0] FN_MULQ   = 7'h20;

	localparam logic [4:0] ZERO_REG = 5'd31; // always reads zero

endpackage

`default_nettype wire

// File: verilog/ex_ctrl_pkg.sv
/*
 * ex_ctrl_pkg: control codes passed from decode to execute,
 * ALU function and operand mux selects
 */
`default_nettype none

package ex_ctrl_pkg;

	localparam int XLEN = 64; // data word width

	typedef enum logic [4:0] {
		ALU_ADDQ,
		ALU_SUBQ,
		ALU_AND,
		ALU_BIC,
		ALU_BIS,
		ALU_ORNOT,
		ALU_XOR,
		ALU_EQV,
		ALU_SRL,
		ALU_SLL,
		ALU_SRA,
		ALU_MULQ,
		ALU_CMPULT,
		ALU_CMPEQ,
		ALU_CMPULE,
		ALU_CMPLT,
		ALU_CMPLE
	} alu_func_e;

	// operand a source
	typedef enum logic [1:0] {
		OPA_IS_REGA,
		OPA_IS_MEM_DISP,
		OPA_IS_NPC,
		OPA_IS_NOT3
	} opa_sel_e;

	// operand b source, code 3 unused
	typedef enum logic [1:0] {
		OPB_IS_REGB,
		OPB_IS_ALU_IMM,
		OPB_IS_BR_DISP
	} opb_sel_e;

endpackage

`default_nettype wire

// File: verilog/regfile.sv
/*
 * regfile: integer register file, two async read ports, one write port,
 * top register hard-wired to zero, write data bypassed to the readers
 */
`default_nettype none

module regfile import ex_ctrl_pkg::*; #(
	parameter int NUM_REGS = 32
) (
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic [$clog2(NUM_REGS)-1:0] rd_addr_a,
	input  wire logic [$clog2(NUM_REGS)-1:0] rd_addr_b,
	input  wire logic                        wr_en,
	input  wire logic [$clog2(NUM_REGS)-1:0] wr_addr,
	input  wire logic [XLEN-1:0]             wr_data,
	output logic      [XLEN-1:0]             rd_a,
	output logic      [XLEN-1:0]             rd_b
);

	localparam int RW = $clog2(NUM_REGS);
	localparam logic [RW-1:0] ZERO_IDX = RW'(NUM_REGS - 1); // last reg reads zero

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en && wr_addr != ZERO_IDX) // zero reg never written
			regs[wr_addr] <= wr_data;
	end

	// zero reg first, so a write to it is never bypassed
	always_comb
	begin
		if (rd_addr_a == ZERO_IDX)
			rd_a = '0;
		else if (wr_en && wr_addr == rd_addr_a)
			rd_a = wr_data; // write-through
		else
			rd_a = regs[rd_addr_a];

		if (rd_addr_b == ZERO_IDX)
			rd_b = '0;
		else if (wr_en && wr_addr == rd_addr_b)
			rd_b = wr_data;
		else
			rd_b = regs[rd_addr_b];
	end

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
/*
 * id_stage: decodes the instruction word, reads the register file and
 * holds the decode/execute register; unknown opcodes become bubbles
 */
`default_nettype none

module id_stage import isa_pkg::*, ex_ctrl_pkg::*; #(
	parameter int NUM_REGS = 32
) (
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic                        if_valid,
	input  wire logic [31:0]                 if_ir,
	input  wire logic [XLEN-1:0]             if_npc,
	input  wire logic [XLEN-1:0]             rd_a,
	input  wire logic [XLEN-1:0]             rd_b,
	output logic      [$clog2(NUM_REGS)-1:0] rd_addr_a,
	output logic      [$clog2(NUM_REGS)-1:0] rd_addr_b,
	output logic      [XLEN-1:0]             id_ex_npc,
	output logic      [31:0]                 id_ex_ir,
	output logic      [XLEN-1:0]             id_ex_rega,
	output logic      [XLEN-1:0]             id_ex_regb,
	output opa_sel_e                         id_ex_opa_sel,
	output opb_sel_e                         id_ex_opb_sel,
	output alu_func_e                        id_ex_alu_func,
	output logic                             id_ex_cond_branch,
	output logic                             id_ex_uncond_branch,
	output logic      [$clog2(NUM_REGS)-1:0] id_ex_dest_reg,
	output logic                             id_ex_wr_en,
	output logic                             id_ex_valid,
	output logic                             id_illegal
);

	localparam int RW = $clog2(NUM_REGS);

	inst_t     inst;
	opa_sel_e  dec_opa_sel;
	opb_sel_e  dec_opb_sel;
	alu_func_e dec_func;
	logic      dec_cond, dec_uncond;
	logic      dec_wr;      // instruction writes a register
	logic      dec_illegal;
	logic [4:0] dec_dest;
	logic      load_ok;     // strobe with a legal opcode

	assign inst = if_ir;

	// register reads straight from the incoming word
	assign rd_addr_a = RW'(inst.op_fmt.ra);
	assign rd_addr_b = RW'(inst.mem_fmt.rb); // same bits as op_fmt.lit[7:3]

	//////////////////////////////
	// decode
	always_comb
	begin
		dec_opa_sel = OPA_IS_REGA;
		dec_opb_sel = OPB_IS_REGB;
		dec_func    = ALU_ADDQ;
		dec_cond    = 1'b0;
		dec_uncond  = 1'b0;
		dec_wr      = 1'b0;
		dec_illegal = 1'b0;
		dec_dest    = inst.op_fmt.rc;
		case (inst.op_fmt.opcode)
			OP_INTA, OP_INTL, OP_INTS, OP_INTM:
			begin
				dec_opb_sel = inst.op_fmt.lit_flag ? OPB_IS_ALU_IMM : OPB_IS_REGB;
				dec_wr      = 1'b1;
				case ({inst.op_fmt.opcode[1:0], inst.op_fmt.func}) // group + func
					{2'd0, FN_ADDQ}:   dec_func = ALU_ADDQ;
					{2'd0, FN_SUBQ}:   dec_func = ALU_SUBQ;
					{2'd0, FN_CMPULT}: dec_func = ALU_CMPULT;
					{2'd0, FN_CMPEQ}:  dec_func = ALU_CMPEQ;
					{2'd0, FN_CMPULE}: dec_func = ALU_CMPULE;
					{2'd0, FN_CMPLT}:  dec_func = ALU_CMPLT;
					{2'd0, FN_CMPLE}:  dec_func = ALU_CMPLE;
					{2'd1, FN_AND}:    dec_func = ALU_AND;
					{2'd1, FN_BIC}:    dec_func = ALU_BIC;
					{2'd1, FN_BIS}:    dec_func = ALU_BIS;
					{2'd1, FN_ORNOT}:  dec_func = ALU_ORNOT;
					{2'd1, FN_XOR}:    dec_func = ALU_XOR;
					{2'd1, FN_EQV}:    dec_func = ALU_EQV;
					{2'd2, FN_SRL}:    dec_func = ALU_SRL;
					{2'd2, FN_SLL}:    dec_func = ALU_SLL;
					{2'd2, FN_SRA}:    dec_func = ALU_SRA;
					{2'd3, FN_MULQ}:   dec_func = ALU_MULQ;
					default:           dec_illegal = 1'b1; // unknown func in group
				endcase
			end
			OP_LDA:
			begin
				dec_opa_sel = OPA_IS_MEM_DISP; // disp + rb
				dec_dest    = inst.mem_fmt.ra;
				dec_wr      = 1'b1;
			end
			OP_BR:
			begin
				dec_opa_sel = OPA_IS_NPC; // target = npc + disp*4
				dec_opb_sel = OPB_IS_BR_DISP;
				dec_uncond  = 1'b1;
			end
			OP_BLBC, OP_BEQ, OP_BLT, OP_BLE, OP_BLBS, OP_BNE, OP_BGE, OP_BGT:
			begin
				dec_opa_sel = OPA_IS_NPC;
				dec_opb_sel = OPB_IS_BR_DISP;
				dec_cond    = 1'b1; // condition tested on rega in ex
			end
			default: dec_illegal = 1'b1;
		endcase
	end

	assign load_ok = if_valid & ~dec_illegal;

	//////////////////////////////
	// decode/execute register, control part
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			id_ex_valid         <= 1'b0;
			id_ex_wr_en         <= 1'b0;
			id_ex_cond_branch   <= 1'b0;
			id_ex_uncond_branch <= 1'b0;
			id_illegal          <= 1'b0;
		end
		else
		begin
			id_ex_valid         <= load_ok; // bubble when no strobe
			id_ex_wr_en         <= load_ok & dec_wr & (dec_dest != ZERO_REG);
			id_ex_cond_branch   <= load_ok & dec_cond;
			id_ex_uncond_branch <= load_ok & dec_uncond;
			id_illegal          <= if_valid & dec_illegal; // one-cycle pulse
		end
	end

	// payload, only loaded on a strobe
	always_ff @(posedge clock)
	begin
		if (if_valid)
		begin
			id_ex_npc      <= if_npc;
			id_ex_ir       <= if_ir;
			id_ex_rega     <= rd_a;
			id_ex_regb     <= rd_b;
			id_ex_opa_sel  <= dec_opa_sel;
			id_ex_opb_sel  <= dec_opb_sel;
			id_ex_alu_func <= dec_func;
			id_ex_dest_reg <= RW'(dec_dest);
		end
	end

endmodule

`default_nettype wire

// File: verilog/alu.sv
/*
 * alu: combinational 64-bit integer ALU, one result per function code
 */
`default_nettype none

module alu import ex_ctrl_pkg::*; (
	input  wire logic [XLEN-1:0] opa,
	input  wire logic [XLEN-1:0] opb,
	input  alu_func_e            func,
	output logic      [XLEN-1:0] result
);

	logic [6:0] fill_sh; // left shift that places the sign fill for sra

	// signed less-than on unsigned vectors
	function automatic logic signed_lt(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		if (a[XLEN-1] == b[XLEN-1])
			return a < b;    // same sign, plain compare works
		else
			return a[XLEN-1]; // a negative means a smaller
	endfunction

	// opb of 0 gives 64, fill shifted fully out
	assign fill_sh = 7'd64 - {1'b0, opb[5:0]};

	always_comb
	begin
		case (func)
			ALU_ADDQ:   result = opa + opb;
			ALU_SUBQ:   result = opa - opb;
			ALU_AND:    result = opa & opb;
			ALU_BIC:    result = opa & ~opb;
			ALU_BIS:    result = opa | opb;
			ALU_ORNOT:  result = opa | ~opb;
			ALU_XOR:    result = opa ^ opb;
			ALU_EQV:    result = opa ^ ~opb;
			ALU_SRL:    result = opa >> opb[5:0];
			ALU_SLL:    result = opa << opb[5:0];
			ALU_SRA:    result = (opa >> opb[5:0]) | ({XLEN{opa[XLEN-1]}} << fill_sh);
			ALU_MULQ:   result = opa * opb; // low 64 bits
			ALU_CMPULT: result = {{(XLEN-1){1'b0}}, opa < opb};
			ALU_CMPEQ:  result = {{(XLEN-1){1'b0}}, opa == opb};
			ALU_CMPULE: result = {{(XLEN-1){1'b0}}, opa <= opb};
			ALU_CMPLT:  result = {{(XLEN-1){1'b0}}, signed_lt(opa, opb)};
			ALU_CMPLE:  result = {{(XLEN-1){1'b0}}, signed_lt(opa, opb) || opa == opb};
			default:    result = 64'hdeadbeefbaadbeef; // marker for a bad code
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/ex_stage.sv
/*
 * ex_stage: operand selection, ALU and branch condition for the
 * instruction held in the decode/execute register, all combinational
 */
`default_nettype none

//////////////////////////////
// branch condition tester

module brcond import ex_ctrl_pkg::*; (
	input  wire logic [XLEN-1:0] opa,  // rega value
	input  wire logic [2:0]      func, // ir[28:26]
	output logic                 cond
);

	logic base; // condition before the negate bit

	always_comb
	begin
		case (func[1:0])
			2'b00: base = ~opa[0];                     // lbc
			2'b01: base = (opa == '0);                  // eq
			2'b10: base = opa[XLEN-1];                  // lt, sign bit
			2'b11: base = opa[XLEN-1] | (opa == '0);    // le
			default: base = 1'b0;
		endcase
		cond = func[2] ? ~base : base; // lbs, ne, ge, gt
	end

endmodule

//////////////////////////////
// execute stage

module ex_stage import ex_ctrl_pkg::*; (
	input  wire logic [XLEN-1:0] id_ex_npc,
	input  wire logic [31:0]     id_ex_ir,
	input  wire logic [XLEN-1:0] id_ex_rega,
	input  wire logic [XLEN-1:0] id_ex_regb,
	input  opa_sel_e             id_ex_opa_sel,
	input  opb_sel_e             id_ex_opb_sel,
	input  alu_func_e            id_ex_alu_func,
	input  wire logic            id_ex_cond_branch,
	input  wire logic            id_ex_uncond_branch,
	output logic      [XLEN-1:0] ex_alu_result,
	output logic                 ex_take_branch
);

	logic [XLEN-1:0] mem_disp, br_disp, alu_imm;
	logic [XLEN-1:0] opa_mux, opb_mux;
	logic            br_cond;

	// immediates from the held word
	assign mem_disp = {{48{id_ex_ir[15]}}, id_ex_ir[15:0]};         // sign-extended
	assign br_disp  = {{41{id_ex_ir[20]}}, id_ex_ir[20:0], 2'b00};  // words to bytes
	assign alu_imm  = {56'd0, id_ex_ir[20:13]};                     // zero-extended literal

	always_comb
	begin
		case (id_ex_opa_sel)
			OPA_IS_REGA:     opa_mux = id_ex_rega;
			OPA_IS_MEM_DISP: opa_mux = mem_disp;
			OPA_IS_NPC:      opa_mux = id_ex_npc;
			OPA_IS_NOT3:     opa_mux = ~64'h3; // align mask
			default:         opa_mux = id_ex_rega;
		endcase
	end

	always_comb
	begin
		case (id_ex_opb_sel)
			OPB_IS_REGB:    opb_mux = id_ex_regb;
			OPB_IS_ALU_IMM: opb_mux = alu_imm;
			OPB_IS_BR_DISP: opb_mux = br_disp;
			default:        opb_mux = 64'hbaadbeefdeadbeef; // shows a bad select
		endcase
	end

	alu alu0 (
		.opa    (opa_mux),
		.opb    (opb_mux),
		.func   (id_ex_alu_func),
		.result (ex_alu_result)
	);

	brcond brcond0 (
		.opa  (id_ex_rega),
		.func (id_ex_ir[28:26]),
		.cond (br_cond)
	);

	// taken when unconditional, or conditional and true
	assign ex_take_branch = id_ex_uncond_branch | (id_ex_cond_branch & br_cond);

endmodule

`default_nettype wire

// File: verilog/exec_top.sv
/*
 * exec_top: two-stage integer execute slice, decode with register read,
 * then execute with write-back to the register file
 */
`default_nettype none

module exec_top import ex_ctrl_pkg::*; #(
	parameter int NUM_REGS = 32
) (
	input  wire logic                        clock,
	input  wire logic                        reset,
	input  wire logic                        if_valid,
	input  wire logic [31:0]                 if_ir,
	input  wire logic [XLEN-1:0]             if_npc,
	output logic                             ex_valid,
	output logic      [XLEN-1:0]             ex_alu_result,
	output logic                             ex_take_branch,
	output logic      [$clog2(NUM_REGS)-1:0] ex_dest_reg,
	output logic                             ex_wr_en,
	output logic                             id_illegal
);

	localparam int RW = $clog2(NUM_REGS);

	logic [RW-1:0]   rd_addr_a, rd_addr_b;
	logic [XLEN-1:0] rd_a, rd_b;
	logic [XLEN-1:0] id_ex_npc, id_ex_rega, id_ex_regb;
	logic [31:0]     id_ex_ir;
	opa_sel_e        id_ex_opa_sel;
	opb_sel_e        id_ex_opb_sel;
	alu_func_e       id_ex_alu_func;
	logic            id_ex_cond_branch, id_ex_uncond_branch;
	logic [RW-1:0]   id_ex_dest_reg;
	logic            id_ex_wr_en, id_ex_valid;

	assign ex_valid    = id_ex_valid;
	assign ex_dest_reg = id_ex_dest_reg;
	assign ex_wr_en    = id_ex_valid & id_ex_wr_en; // write-back only for a live instr

	regfile #(.NUM_REGS(NUM_REGS)) rf0 (
		.clock     (clock),
		.reset     (reset),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.wr_en     (ex_wr_en),
		.wr_addr   (id_ex_dest_reg),
		.wr_data   (ex_alu_result), // end of ex cycle
		.rd_a      (rd_a),
		.rd_b      (rd_b)
	);

	id_stage #(.NUM_REGS(NUM_REGS)) id0 (
		.clock               (clock),
		.reset               (reset),
		.if_valid            (if_valid),
		.if_ir               (if_ir),
		.if_npc              (if_npc),
		.rd_a                (rd_a),
		.rd_b                (rd_b),
		.rd_addr_a           (rd_addr_a),
		.rd_addr_b           (rd_addr_b),
		.id_ex_npc           (id_ex_npc),
		.id_ex_ir            (id_ex_ir),
		.id_ex_rega          (id_ex_rega),
		.id_ex_regb          (id_ex_regb),
		.id_ex_opa_sel       (id_ex_opa_sel),
		.id_ex_opb_sel       (id_ex_opb_sel),
		.id_ex_alu_func      (id_ex_alu_func),
		.id_ex_cond_branch   (id_ex_cond_branch),
		.id_ex_uncond_branch (id_ex_uncond_branch),
		.id_ex_dest_reg      (id_ex_dest_reg),
		.id_ex_wr_en         (id_ex_wr_en),
		.id_ex_valid         (id_ex_valid),
		.id_illegal          (id_illegal)
	);

	ex_stage ex0 (
		.id_ex_npc           (id_ex_npc),
		.id_ex_ir            (id_ex_ir),
		.id_ex_rega          (id_ex_rega),
		.id_ex_regb          (id_ex_regb),
		.id_ex_opa_sel       (id_ex_opa_sel),
		.id_ex_opb_sel       (id_ex_opb_sel),
		.id_ex_alu_func      (id_ex_alu_func),
		.id_ex_cond_branch   (id_ex_cond_branch),
		.id_ex_uncond_branch (id_ex_uncond_branch),
		.ex_alu_result       (ex_alu_result),
		.ex_take_branch      (ex_take_branch)
	);

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
/*
 * tb_clock: free-running testbench clock, low at time zero
 */
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 20
) (
	output logic clock
);

	initial
	begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock; // half period high, half low
	end

endmodule

`default_nettype wire

// File: tests/exec_top_tb.sv
/*
 * exec_top_tb drives directed tests into the two-stage execute slice;
 * a shadow register file and a small reference model give the expected results
 */
`default_nettype none

module exec_top_tb import isa_pkg::*;;

	logic        clock;
	logic        reset;
	logic        if_valid;
	logic [31:0] if_ir;
	logic [63:0] if_npc;
	logic        ex_valid;
	logic [63:0] ex_alu_result;
	logic        ex_take_branch;
	logic [4:0]  ex_dest_reg;
	logic        ex_wr_en;
	logic        id_illegal;

	logic [63:0] shadow [32];          // expected register contents
	logic [63:0] pc;                   // npc handed to the next instruction
	logic [63:0] lcg_state = 64'd8;
	int          errors;
	int          checks;

	// expected response of the instruction in execute
	logic        exp_legal, exp_wr, exp_take, exp_chk_dest;
	logic [63:0] exp_res;
	logic [4:0]  exp_dest;

	tb_clock #(.PERIOD(20)) clk0 (.clock(clock));

	exec_top #(.NUM_REGS(32)) dut0 (
		.clock          (clock),
		.reset          (reset),
		.if_valid       (if_valid),
		.if_ir          (if_ir),
		.if_npc         (if_npc),
		.ex_valid       (ex_valid),
		.ex_alu_result  (ex_alu_result),
		.ex_take_branch (ex_take_branch),
		.ex_dest_reg    (ex_dest_reg),
		.ex_wr_en       (ex_wr_en),
		.id_illegal     (id_illegal)
	);

	//////////////////////////////
	// helpers

	function automatic logic [63:0] lcg_next();
		lcg_state = lcg_state * 64'h5851f42d4c957f2d + 64'h14057b7ef767814f;
		return lcg_state;
	endfunction

	// register form with rb in lit[7:3]
	function automatic logic [31:0] op_word(input logic [5:0] op, input logic [4:0] ra,
		input logic [4:0] rb, input logic [6:0] fn, input logic [4:0] rc);
		inst_t i;
		i.bits = '0;
		i.op_fmt.opcode = op;
		i.op_fmt.ra     = ra;
		i.op_fmt.lit    = {rb, 3'b000};
		i.op_fmt.func   = fn;
		i.op_fmt.rc     = rc;
		return i.bits;
	endfunction

	function automatic logic [31:0] lit_word(input logic [5:0] op, input logic [4:0] ra,
		input logic [7:0] lit, input logic [6:0] fn, input logic [4:0] rc);
		inst_t i;
		i.bits = '0;
		i.op_fmt.opcode   = op;
		i.op_fmt.ra       = ra;
		i.op_fmt.lit      = lit;
		i.op_fmt.lit_flag = 1'b1;
		i.op_fmt.func     = fn;
		i.op_fmt.rc       = rc;
		return i.bits;
	endfunction

	function automatic logic [31:0] mem_word(input logic [5:0] op, input logic [4:0] ra,
		input logic [4:0] rb, input logic [15:0] disp);
		inst_t i;
		i.mem_fmt.opcode = op;
		i.mem_fmt.ra     = ra;
		i.mem_fmt.rb     = rb;
		i.mem_fmt.disp   = disp;
		return i.bits;
	endfunction

	function automatic logic [31:0] br_word(input logic [5:0] op, input logic [4:0] ra,
		input logic [20:0] disp);
		return {op, ra, disp};
	endfunction

	// condition table on the signed view of rega
	function automatic logic branch_taken(input logic [5:0] op, input logic [63:0] v);
		case (op)
			OP_BLBC: return !v[0];
			OP_BEQ:  return v == 64'd0;
			OP_BLT:  return $signed(v) < 0;
			OP_BLE:  return $signed(v) <= 0;
			OP_BLBS: return v[0];
			OP_BNE:  return v != 64'd0;
			OP_BGE:  return $signed(v) >= 0;
			default: return $signed(v) > 0; // bgt
		endcase
	endfunction

	// reference model over the shadow registers
	function automatic void compute_expected(input logic [31:0] ir, input logic [63:0] npc);
		inst_t       i;
		logic [63:0] a;
		logic [63:0] b;
		i            = ir;
		a            = shadow[i.op_fmt.ra];
		b            = i.op_fmt.lit_flag ? {56'd0, i.op_fmt.lit} : shadow[i.mem_fmt.rb];
		exp_legal    = 1'b1;
		exp_wr       = 1'b0;
		exp_take     = 1'b0;
		exp_chk_dest = 1'b0;
		exp_res      = '0;
		exp_dest     = i.op_fmt.rc;
		case (i.op_fmt.opcode)
			OP_INTA:
				case (i.op_fmt.func)
					FN_ADDQ:   exp_res = a + b;
					FN_SUBQ:   exp_res = a - b;
					FN_CMPULT: exp_res = {63'd0, a < b};
					FN_CMPEQ:  exp_res = {63'd0, a == b};
					FN_CMPULE: exp_res = {63'd0, a <= b};
					FN_CMPLT:  exp_res = {63'd0, $signed(a) < $signed(b)};
					FN_CMPLE:  exp_res = {63'd0, $signed(a) <= $signed(b)};
					default:   exp_legal = 1'b0;
				endcase
			OP_INTL:
				case (i.op_fmt.func)
					FN_AND:   exp_res = a & b;
					FN_BIC:   exp_res = a & ~b;
					FN_BIS:   exp_res = a | b;
					FN_ORNOT: exp_res = a | ~b;
					FN_XOR:   exp_res = a ^ b;
					FN_EQV:   exp_res = ~(a ^ b);
					default:  exp_legal = 1'b0;
				endcase
			OP_INTS:
				case (i.op_fmt.func)
					FN_SRL:  exp_res = a >> b[5:0];
					FN_SLL:  exp_res = a << b[5:0];
					FN_SRA:  exp_res = $signed(a) >>> b[5:0];
					default: exp_legal = 1'b0;
				endcase
			OP_INTM:
				if (i.op_fmt.func == FN_MULQ)
					exp_res = a * b;
				else
					exp_legal = 1'b0;
			OP_LDA:
			begin
				exp_res  = {{48{i.mem_fmt.disp[15]}}, i.mem_fmt.disp} + shadow[i.mem_fmt.rb];
				exp_dest = i.mem_fmt.ra;
			end
			OP_BR, OP_BLBC, OP_BEQ, OP_BLT, OP_BLE, OP_BLBS, OP_BNE, OP_BGE, OP_BGT:
			begin
				exp_res  = npc + {{43{i.bits[20]}}, i.bits[20:0]} * 64'd4;
				exp_take = (i.op_fmt.opcode == OP_BR) ? 1'b1 : branch_taken(i.op_fmt.opcode, a);
			end
			default: exp_legal = 1'b0;
		endcase
		// operates and lda write their destination unless it is the zero reg
		if (exp_legal && (i.op_fmt.opcode[5:4] == 2'b01 || i.op_fmt.opcode == OP_LDA))
		begin
			exp_chk_dest = 1'b1;
			exp_wr       = (exp_dest != ZERO_REG);
		end
	endfunction

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("Error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic verify_outputs();
		compare("ex_valid", ex_valid, exp_legal);
		compare("id_illegal", id_illegal, !exp_legal);
		compare("ex_wr_en", ex_wr_en, exp_legal && exp_wr);
		compare("ex_take_branch", ex_take_branch, exp_legal && exp_take);
		if (exp_legal)
			compare("ex_alu_result", ex_alu_result, exp_res);
		if (exp_chk_dest)
			compare("ex_dest_reg", ex_dest_reg, exp_dest);
		if (exp_legal && exp_wr)
			shadow[exp_dest] = exp_res; // written at the end of this cycle
	endtask

	//////////////////////////////
	// drive and wait

	task automatic drive_inst(input logic [31:0] ir, input logic [63:0] npc);
		@(posedge clock);
		#1;
		if_valid = 1'b1;
		if_ir    = ir;
		if_npc   = npc;
	endtask

	task automatic release_strobe();
		@(posedge clock);
		#1;
		if_valid = 1'b0;
	endtask

	// sampled mid cycle where outputs are settled
	task automatic wait_ex();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (!(ex_valid || id_illegal) && cycles < 20)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!(ex_valid || id_illegal))
		begin
			$display("timeout: no instruction reached execute within 20 cycles");
			errors++;
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("Test failed");
			$finish;
		end
		else if (cycles != 0)
		begin
			$display("late response: instruction reached execute %0d cycles too late", cycles);
			errors++;
		end
	endtask

	task automatic run_inst(input logic [31:0] ir);
		logic [63:0] npc;
		npc = pc;
		pc  = pc + 64'd4;
		drive_inst(ir, npc);
		release_strobe();
		wait_ex();
		compute_expected(ir, npc);
		verify_outputs();
	endtask

	// second word strobed the cycle after the first
	task automatic issue_pair(input logic [31:0] ir1, input logic [31:0] ir2);
		logic [63:0] npc1;
		logic [63:0] npc2;
		npc1 = pc;
		npc2 = pc + 64'd4;
		pc   = pc + 64'd8;
		drive_inst(ir1, npc1);
		drive_inst(ir2, npc2);
		wait_ex();                 // first one in execute
		compute_expected(ir1, npc1);
		verify_outputs();
		release_strobe();
		wait_ex();
		compute_expected(ir2, npc2); // sees the first result
		verify_outputs();
	endtask

	// random 64-bit value built from lda and 16-bit shifts
	task automatic load_rand(input logic [4:0] rg);
		logic [63:0] r;
		r = lcg_next();
		run_inst(mem_word(OP_LDA, rg, ZERO_REG, r[63:48]));
		for (int s = 0; s < 3; s++)
		begin
			run_inst(lit_word(OP_INTS, rg, 8'd16, FN_SLL, rg));
			r = lcg_next();
			run_inst(mem_word(OP_LDA, rg, rg, r[63:48])); // adds to the shifted value
		end
	endtask

	//////////////////////////////
	// directed tests

	task automatic check_reset_state();
		@(negedge clock);
		compare("ex_valid", ex_valid, 0);
		compare("ex_wr_en", ex_wr_en, 0);
		compare("ex_take_branch", ex_take_branch, 0);
		compare("id_illegal", id_illegal, 0);
		run_inst(op_word(OP_INTA, 5'd1, 5'd2, FN_ADDQ, 5'd3)); // cleared regs give 0
	endtask

	task automatic load_displacements();
		run_inst(mem_word(OP_LDA, 5'd1, ZERO_REG, 16'h7fff));
		run_inst(mem_word(OP_LDA, 5'd2, ZERO_REG, 16'h8000)); // most negative
		run_inst(mem_word(OP_LDA, 5'd3, ZERO_REG, 16'hffff));
		run_inst(mem_word(OP_LDA, 5'd4, ZERO_REG, 16'h0001));
		run_inst(mem_word(OP_LDA, 5'd5, ZERO_REG, 16'h1234));
		run_inst(mem_word(OP_LDA, 5'd6, ZERO_REG, 16'hc0de));
		run_inst(mem_word(OP_LDA, 5'd7, 5'd5, 16'hfff0));     // nonzero base
		run_inst(mem_word(OP_LDA, ZERO_REG, 5'd5, 16'h0010)); // no write
		for (int k = 1; k < 8; k++)
			run_inst(op_word(OP_INTL, 5'(k), ZERO_REG, FN_BIS, 5'd8)); // read back
		run_inst(op_word(OP_INTL, ZERO_REG, ZERO_REG, FN_BIS, 5'd8));
	endtask

	task automatic run_operate_groups();
		logic [12:0] op_list [17];
		logic [5:0]  op;
		logic [6:0]  fn;
		logic [63:0] r;
		op_list = '{{OP_INTA, FN_ADDQ}, {OP_INTA, FN_SUBQ}, {OP_INTA, FN_CMPULT},
			{OP_INTA, FN_CMPEQ}, {OP_INTA, FN_CMPULE}, {OP_INTA, FN_CMPLT},
			{OP_INTA, FN_CMPLE}, {OP_INTL, FN_AND}, {OP_INTL, FN_BIC},
			{OP_INTL, FN_BIS}, {OP_INTL, FN_ORNOT}, {OP_INTL, FN_XOR},
			{OP_INTL, FN_EQV}, {OP_INTS, FN_SRL}, {OP_INTS, FN_SLL},
			{OP_INTS, FN_SRA}, {OP_INTM, FN_MULQ}};
		for (int k = 0; k < 17; k++)
		begin
			op = op_list[k][12:7];
			fn = op_list[k][6:0];
			load_rand(5'd1);
			load_rand(5'd2);
			r = lcg_next();
			run_inst(op_word(op, 5'd1, 5'd2, fn, 5'd3));
			run_inst(op_word(op, 5'd2, 5'd1, fn, 5'd4));    // swapped operands
			run_inst(lit_word(op, 5'd1, r[63:56], fn, 5'd5));
			run_inst(op_word(op, 5'd1, 5'd1, fn, 5'd6));    // equal operands
		end
		// zero reg as destination
		run_inst(op_word(OP_INTA, 5'd1, 5'd2, FN_ADDQ, ZERO_REG));
		run_inst(op_word(OP_INTL, ZERO_REG, ZERO_REG, FN_ORNOT, 5'd7)); // all ones
		run_inst(op_word(OP_INTL, ZERO_REG, ZERO_REG, FN_BIS, 5'd7));
	endtask

	task automatic chain_dependents();
		issue_pair(mem_word(OP_LDA, 5'd10, ZERO_REG, 16'h0123),
			op_word(OP_INTA, 5'd10, 5'd10, FN_ADDQ, 5'd11));
		issue_pair(op_word(OP_INTM, 5'd11, 5'd10, FN_MULQ, 5'd12),
			op_word(OP_INTA, 5'd1, 5'd12, FN_SUBQ, 5'd13));   // rb dependent
		issue_pair(lit_word(OP_INTS, 5'd13, 8'd3, FN_SLL, 5'd13),
			lit_word(OP_INTA, 5'd13, 8'd7, FN_CMPLT, 5'd14));
		issue_pair(op_word(OP_INTL, 5'd13, 5'd1, FN_XOR, 5'd15),
			mem_word(OP_LDA, 5'd16, 5'd15, 16'h8001));       // lda base
		issue_pair(mem_word(OP_LDA, 5'd17, ZERO_REG, 16'hfffe),
			br_word(OP_BLT, 5'd17, 21'h000010));             // branch on fresh rega
		issue_pair(op_word(OP_INTA, 5'd1, 5'd2, FN_ADDQ, ZERO_REG),
			op_word(OP_INTL, ZERO_REG, ZERO_REG, FN_BIS, 5'd18)); // zero reg not bypassed
	endtask

	task automatic exercise_branches();
		logic [5:0]  bops [9];
		logic [15:0] vals [4];
		logic [63:0] r;
		bops = '{OP_BR, OP_BLBC, OP_BEQ, OP_BLT, OP_BLE, OP_BLBS, OP_BNE, OP_BGE, OP_BGT};
		vals = '{16'h0000, 16'hfffb, 16'h0007, 16'h000c}; // zero, neg, odd, even
		for (int b = 0; b < 9; b++)
		begin
			for (int v = 0; v < 4; v++)
			begin
				run_inst(mem_word(OP_LDA, 5'd1, ZERO_REG, vals[v]));
				r  = lcg_next();
				pc = {r[63:2], 2'b00};
				r  = lcg_next();
				run_inst(br_word(bops[b], 5'd1, r[63:43]));
			end
		end
	endtask

	task automatic reject_illegal();
		run_inst(mem_word(6'h01, 5'd1, 5'd2, 16'h1234));
		@(negedge clock);
		compare("id_illegal", id_illegal, 0); // single cycle pulse
		run_inst(op_word(OP_INTA, 5'd1, 5'd2, 7'h7f, 5'd1)); // unknown func
		run_inst(mem_word(6'h28, 5'd3, ZERO_REG, 16'h0042));  // loads are not supported
		for (int k = 1; k < 4; k++)
			run_inst(op_word(OP_INTL, 5'(k), ZERO_REG, FN_BIS, 5'd9)); // unchanged
	endtask

	//////////////////////////////
	// main sequence

	initial
	begin
		reset    = 1'b1;
		if_valid = 1'b0;
		if_ir    = '0;
		if_npc   = '0;
		pc       = 64'h0000_0000_0001_0000;
		errors   = 0;
		checks   = 0;
		for (int k = 0; k < 32; k++)
			shadow[k] = '0;
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;

		check_reset_state();
		load_displacements();
		run_operate_groups();
		chain_dependents();
		exercise_branches();
		reject_illegal();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
verilog/isa_pkg.sv
verilog/ex_ctrl_pkg.sv
verilog/regfile.sv
verilog/id_stage.sv
verilog/alu.sv
verilog/ex_stage.sv
verilog/exec_top.sv
tests/tb_clock.sv
tests/exec_top_tb.sv

// File: run.sh
#!/bin/sh
# build and run the execute slice testbench with Verilator
verilator --binary --timing -Wno-fatal --top-module exec_top_tb -f flist.f \
	-o exec_top_sim > build.log 2>&1 \
	&& ./obj_dir/exec_top_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Test passed" sim.log && echo "simulation PASS" \
	|| { echo "simulation FAIL, see sim.log"; exit 1; }
